// ==== rtl/cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

    typedef logic [31:0] word_t;       // Data, address or PC
    typedef logic [4:0]  creg_addr_t;
    typedef logic [4:0]  exccode_t;

    // ##################################################
    // Exception codes
    // ##################################################
    localparam exccode_t CODE_INT  = 5'd0;
    localparam exccode_t CODE_ADEL = 5'd4;  // Fetch or load
    localparam exccode_t CODE_ADES = 5'd5;
    localparam exccode_t CODE_SYS  = 5'd8;
    localparam exccode_t CODE_BP   = 5'd9;
    localparam exccode_t CODE_RI   = 5'd10;
    localparam exccode_t CODE_OV   = 5'd12;

    // ##################################################
    // Register numbers
    // ##################################################
    localparam creg_addr_t REG_BADVADDR = 5'd8;
    localparam creg_addr_t REG_COUNT    = 5'd9;
    localparam creg_addr_t REG_COMPARE  = 5'd11;
    localparam creg_addr_t REG_STATUS   = 5'd12;
    localparam creg_addr_t REG_CAUSE    = 5'd13;
    localparam creg_addr_t REG_EPC      = 5'd14;
    localparam creg_addr_t REG_CONFIG   = 5'd16;

    localparam word_t CONFIG_ID = 32'h8000_0480;

    typedef struct packed {
        logic [8:0] zero_31_23;
        logic       bev;            // Bit 22
        logic [5:0] zero_21_16;
        logic [7:0] im;
        logic [4:0] zero_7_3;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic        bd;            // Bit 31
        logic        ti;
        logic [13:0] zero_29_16;
        logic [7:0]  ip;
        logic        zero_7;
        exccode_t    exccode;
        logic [1:0]  zero_1_0;
    } cause_t;

    typedef struct packed {
        word_t   badvaddr;
        word_t   count;
        word_t   compare;
        status_t status;
        cause_t  cause;
        word_t   epc;
        word_t   config_;
    } cp0_regs_t;

    localparam cp0_regs_t CP0_INIT = '{
        status:  '{bev: 1'b1, erl: 1'b1, default: '0},
        config_: CONFIG_ID,
        default: '0
    };

    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } cp0_write_t;

    // Report from the exception-resolving stage
    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  in_delay_slot;
        logic  fetch_addr_err;
        logic  reserved_instr;
        logic  overflow;
        logic  syscall;
        logic  brk;
        logic  load_addr_err;
        logic  store_addr_err;
        word_t data_addr;
    } excep_req_t;

    typedef struct packed {
        logic     valid;
        exccode_t code;
        word_t    pc;
        logic     in_delay_slot;
        word_t    badvaddr;
    } exception_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== rtl/cp0.sv ====
`default_nettype none

module cp0 (
    input  logic                clk,
    input  logic                reset,
    input  cp0_pkg::cp0_write_t cwrite,
    input  cp0_pkg::creg_addr_t ra,
    output cp0_pkg::word_t      rd,
    input  logic                is_eret,
    input  logic [4:0]          hw_int,
    input  cp0_pkg::exception_t exception,
    output cp0_pkg::cp0_regs_t  regs
);

    cp0_pkg::cp0_regs_t cp0_q;
    cp0_pkg::cp0_regs_t cp0_d;
    logic               count_phase;
    logic               timer_flag;
    logic               compare_write;
    logic               is_addr_err;

    // ##################################################
    // State
    // ##################################################
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            cp0_q <= cp0_pkg::CP0_INIT;
        end else begin
            cp0_q <= cp0_d;
        end
    end

    // Count runs at half the clock rate
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count_phase <= 1'b0;
        end else begin
            count_phase <= ~count_phase;
        end
    end

    assign compare_write = cwrite.wen && (cwrite.addr == cp0_pkg::REG_COMPARE);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            timer_flag <= 1'b0;
        end else if (compare_write) begin
            timer_flag <= 1'b0;     // Acknowledge
        end else if (cp0_q.count == cp0_q.compare) begin
            timer_flag <= 1'b1;
        end
    end

    // Live view with the pending lines merged into Cause
    always_comb begin
        regs = cp0_q;
        regs.cause.ti      = timer_flag;
        regs.cause.ip[7]   = timer_flag;
        regs.cause.ip[6:2] = hw_int;
    end

    // ##################################################
    // Read port
    // ##################################################
    always_comb begin
        case (ra)
            cp0_pkg::REG_BADVADDR: rd = regs.badvaddr;
            cp0_pkg::REG_COUNT:    rd = regs.count;
            cp0_pkg::REG_COMPARE:  rd = regs.compare;
            cp0_pkg::REG_STATUS:   rd = regs.status;
            cp0_pkg::REG_CAUSE:    rd = regs.cause;
            cp0_pkg::REG_EPC:      rd = regs.epc;
            cp0_pkg::REG_CONFIG:   rd = regs.config_;
            default:               rd = '0;
        endcase
    end

    // ##################################################
    // Next state
    // ##################################################
    assign is_addr_err = (exception.code == cp0_pkg::CODE_ADEL) ||
                         (exception.code == cp0_pkg::CODE_ADES);

    always_comb begin
        cp0_d = regs;
        cp0_d.count = regs.count + {31'b0, count_phase};

        if (cwrite.wen) begin
            case (cwrite.addr)
                cp0_pkg::REG_COUNT:   cp0_d.count   = cwrite.wd;
                cp0_pkg::REG_COMPARE: cp0_d.compare = cwrite.wd;
                cp0_pkg::REG_STATUS: begin
                    cp0_d.status.im  = cwrite.wd[15:8];
                    cp0_d.status.exl = cwrite.wd[1];
                    cp0_d.status.ie  = cwrite.wd[0];
                end
                cp0_pkg::REG_CAUSE:   cp0_d.cause.ip[1:0] = cwrite.wd[9:8];  // Soft bits
                cp0_pkg::REG_EPC:     cp0_d.epc     = cwrite.wd;
                default: ;
            endcase
        end

        if (exception.valid) begin
            // Nested entry keeps the first EPC and BD
            if (!regs.status.exl) begin
                cp0_d.cause.bd = exception.in_delay_slot;
                if (exception.in_delay_slot) begin
                    cp0_d.epc = exception.pc - 32'd4;
                end else begin
                    cp0_d.epc = exception.pc;
                end
            end
            cp0_d.cause.exccode = exception.code;
            cp0_d.status.exl    = 1'b1;
            if (is_addr_err) begin
                cp0_d.badvaddr = exception.badvaddr;
            end
        end else if (is_eret) begin
            if (regs.status.erl) begin
                cp0_d.status.erl = 1'b0;
            end else begin
                cp0_d.status.exl = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exception_unit.sv ====
`default_nettype none

module exception_unit #(
    parameter cp0_pkg::word_t EXC_VECTOR = 32'hBFC0_0380
) (
    input  cp0_pkg::excep_req_t req,
    input  cp0_pkg::cp0_regs_t  regs,
    input  logic                is_eret,
    output cp0_pkg::exception_t exception,
    output cp0_pkg::redirect_t  redirect
);

    logic              int_enabled;
    logic              int_pending;
    logic              has_cause;
    cp0_pkg::exccode_t code;

    // ##################################################
    // Interrupt condition
    // ##################################################
    assign int_enabled = regs.status.ie && !regs.status.exl && !regs.status.erl;
    assign int_pending = int_enabled && (|(regs.cause.ip & regs.status.im));

    // ##################################################
    // Priority encode
    // ##################################################
    always_comb begin
        has_cause = 1'b1;
        if (int_pending) begin
            code = cp0_pkg::CODE_INT;
        end else if (req.fetch_addr_err) begin
            code = cp0_pkg::CODE_ADEL;
        end else if (req.reserved_instr) begin
            code = cp0_pkg::CODE_RI;
        end else if (req.overflow) begin
            code = cp0_pkg::CODE_OV;
        end else if (req.syscall) begin
            code = cp0_pkg::CODE_SYS;
        end else if (req.brk) begin
            code = cp0_pkg::CODE_BP;
        end else if (req.load_addr_err) begin
            code = cp0_pkg::CODE_ADEL;
        end else if (req.store_addr_err) begin
            code = cp0_pkg::CODE_ADES;
        end else begin
            has_cause = 1'b0;
            code      = cp0_pkg::CODE_INT;
        end
    end

    // Interrupts ride on a valid request too
    assign exception.valid         = req.valid && has_cause;
    assign exception.code          = code;
    assign exception.pc            = req.pc;
    assign exception.in_delay_slot = req.in_delay_slot;
    // Fetch error outranks data errors
    assign exception.badvaddr      = req.fetch_addr_err ? req.pc : req.data_addr;

    // ##################################################
    // Fetch redirect
    // ##################################################
    always_comb begin
        redirect.valid  = exception.valid || is_eret;
        redirect.target = regs.epc;
        if (exception.valid) begin
            redirect.target = EXC_VECTOR;   // Eret dropped
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cp0_subsystem.sv ====
`default_nettype none

module cp0_subsystem #(
    parameter cp0_pkg::word_t EXC_VECTOR = 32'hBFC0_0380
) (
    input  logic                clk,
    input  logic                reset,
    input  cp0_pkg::excep_req_t req,
    input  logic [4:0]          hw_int,
    input  logic                is_eret,
    input  cp0_pkg::cp0_write_t cwrite,
    input  cp0_pkg::creg_addr_t ra,
    output cp0_pkg::word_t      rd,
    output cp0_pkg::redirect_t  redirect
);

    cp0_pkg::cp0_regs_t  regs;
    cp0_pkg::exception_t exception;

    // ##################################################
    // Register file and timer
    // ##################################################
    cp0 u_cp0 (
        .clk       (clk),
        .reset     (reset),
        .cwrite    (cwrite),
        .ra        (ra),
        .rd        (rd),
        .is_eret   (is_eret),
        .hw_int    (hw_int),
        .exception (exception),
        .regs      (regs)
    );

    // Prioritized record and restart target
    exception_unit #(
        .EXC_VECTOR (EXC_VECTOR)
    ) u_exception_unit (
        .req       (req),
        .regs      (regs),
        .is_eret   (is_eret),
        .exception (exception),
        .redirect  (redirect)
    );

endmodule

`default_nettype wire

// ==== dv/cp0_ref_model.svh ====
`ifndef CP0_REF_MODEL_SVH
`define CP0_REF_MODEL_SVH

function automatic logic ref_int_pending(input cp0_pkg::status_t st, input cp0_pkg::cause_t ca);
    return st.ie && !st.exl && !st.erl && ((ca.ip & st.im) != 8'd0);
endfunction

function automatic logic ref_has_cause(input cp0_pkg::excep_req_t r, input logic pend);
    return r.valid && (pend || r.fetch_addr_err || r.reserved_instr || r.overflow ||
                       r.syscall || r.brk || r.load_addr_err || r.store_addr_err);
endfunction

// Highest priority first
function automatic cp0_pkg::exccode_t ref_code(input cp0_pkg::excep_req_t r, input logic pend);
    if (pend) return cp0_pkg::CODE_INT;
    if (r.fetch_addr_err) return cp0_pkg::CODE_ADEL;
    if (r.reserved_instr) return cp0_pkg::CODE_RI;
    if (r.overflow) return cp0_pkg::CODE_OV;
    if (r.syscall) return cp0_pkg::CODE_SYS;
    if (r.brk) return cp0_pkg::CODE_BP;
    if (r.load_addr_err) return cp0_pkg::CODE_ADEL;
    if (r.store_addr_err) return cp0_pkg::CODE_ADES;
    return cp0_pkg::CODE_INT;
endfunction

function automatic cp0_pkg::word_t ref_write(input cp0_pkg::creg_addr_t a,
                                            input cp0_pkg::word_t old,
                                            input cp0_pkg::word_t wd);
    case (a)
        cp0_pkg::REG_COUNT, cp0_pkg::REG_COMPARE, cp0_pkg::REG_EPC: return wd;
        cp0_pkg::REG_STATUS: return (old & ~32'h0000_FF03) | (wd & 32'h0000_FF03);
        cp0_pkg::REG_CAUSE:  return (old & ~32'h0000_0300) | (wd & 32'h0000_0300);
        cp0_pkg::REG_BADVADDR, cp0_pkg::REG_CONFIG: return old;
        default: return 32'd0;
    endcase
endfunction

function automatic cp0_pkg::redirect_t ref_redirect(input logic exc, input logic eret,
                                                    input cp0_pkg::word_t epc,
                                                    input cp0_pkg::word_t vec);
    ref_redirect.valid  = exc || eret;
    ref_redirect.target = exc ? vec : epc;   // Exception beats eret
endfunction

`endif

// ==== dv/cp0_subsystem_tb.sv ====
`default_nettype none

module cp0_subsystem_tb;

    localparam cp0_pkg::word_t VEC = 32'hBFC0_0380;
    // Reset, write masks, entry and nested, eret, timer, interrupts
    localparam int PLANNED_CYCLES = 16 + 32 * 2 + 20 * 6 + 20 + 60 + 40;

    logic                clk;
    logic                reset;
    cp0_pkg::excep_req_t req;
    logic [4:0]          hw_int;
    logic                is_eret;
    cp0_pkg::cp0_write_t cwrite;
    cp0_pkg::creg_addr_t ra;
    cp0_pkg::word_t      rd;
    cp0_pkg::redirect_t  redirect;

    `include "cp0_ref_model.svh"

    cp0_subsystem #(.EXC_VECTOR(VEC)) u_dut (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .hw_int   (hw_int),
        .is_eret  (is_eret),
        .cwrite   (cwrite),
        .ra       (ra),
        .rd       (rd),
        .redirect (redirect)
    );

    always #10 clk = ~clk;

    initial begin
        repeat (2 * PLANNED_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    // ##################################################
    // Compare tasks
    // ##################################################
    task automatic check_word(input string name, input cp0_pkg::word_t exp,
                              input cp0_pkg::word_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_code(input string name, input cp0_pkg::exccode_t exp,
                              input cp0_pkg::exccode_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "code mismatch");
        end
    endtask

    task automatic check_redirect(input string name, input cp0_pkg::redirect_t exp,
                                  input cp0_pkg::redirect_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %b/%h actual %b/%h", name,
                     exp.valid, exp.target, act.valid, act.target);
            $display("TEST FAILED");
            $fatal(1, "redirect mismatch");
        end
    endtask

    // ##################################################
    // Drivers
    // ##################################################
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic read_reg(input cp0_pkg::creg_addr_t a, output cp0_pkg::word_t v);
        ra = a;
        #1;
        v = rd;
    endtask

    task automatic write_reg(input cp0_pkg::creg_addr_t a, input cp0_pkg::word_t wd);
        cwrite = '{wen: 1'b1, addr: a, wd: wd};
        step();
        cwrite = '0;
    endtask

    function automatic cp0_pkg::excep_req_t gen_req();
        cp0_pkg::excep_req_t r;
        logic [31:0]         v;
        r = '0;
        v = $urandom();
        if (v[6:0] == 7'd0) v[3] = 1'b1;   // At least one cause
        r.valid = 1'b1;
        r.pc = $urandom();
        r.pc[1:0] = 2'b00;
        r.in_delay_slot  = v[7];
        r.fetch_addr_err = v[0];
        r.reserved_instr = v[1];
        r.overflow       = v[2];
        r.syscall        = v[3];
        r.brk            = v[4];
        r.load_addr_err  = v[5];
        r.store_addr_err = v[6];
        r.data_addr = $urandom();
        return r;
    endfunction

    task automatic apply_req(input string name, input cp0_pkg::excep_req_t r, input logic eret,
                             output logic taken, output cp0_pkg::exccode_t code);
        cp0_pkg::status_t st;
        cp0_pkg::cause_t  ca;
        cp0_pkg::word_t   epc;
        logic             pend;
        read_reg(cp0_pkg::REG_STATUS, st);
        read_reg(cp0_pkg::REG_CAUSE, ca);
        read_reg(cp0_pkg::REG_EPC, epc);
        pend  = ref_int_pending(st, ca);
        taken = ref_has_cause(r, pend);
        code  = ref_code(r, pend);
        req = r;
        is_eret = eret;
        #1;
        check_redirect(name, ref_redirect(taken, eret, epc, VEC), redirect);
        step();
        req = '0;
        is_eret = 1'b0;
        if (taken) begin
            read_reg(cp0_pkg::REG_CAUSE, ca);
            check_code(name, code, ca.exccode);
            read_reg(cp0_pkg::REG_STATUS, st);
            check_word({name, "_exl"}, 32'd1, {31'b0, st.exl});
        end
    endtask

    task automatic do_eret(input string name);
        cp0_pkg::word_t epc;
        read_reg(cp0_pkg::REG_EPC, epc);
        is_eret = 1'b1;
        #1;
        check_redirect(name, ref_redirect(1'b0, 1'b1, epc, VEC), redirect);
        step();
        is_eret = 1'b0;
    endtask

    // ##################################################
    // Tests
    // ##################################################
    initial begin
        cp0_pkg::word_t      old_v;
        cp0_pkg::word_t      new_v;
        cp0_pkg::word_t      wd;
        cp0_pkg::word_t      exp_epc;
        cp0_pkg::word_t      c0;
        cp0_pkg::status_t    st;
        cp0_pkg::cause_t     ca;
        cp0_pkg::excep_req_t r;
        cp0_pkg::exccode_t   code;
        logic                taken;
        logic                exp_bd;

        void'($urandom(69));
        clk = 1'b0;
        reset = 1'b1;
        req = '0;
        hw_int = '0;
        is_eret = 1'b0;
        cwrite = '0;
        ra = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        step();

        // Write masks over every register number
        for (int a = 0; a < 32; a++) begin
            read_reg(a[4:0], old_v);
            wd = $urandom();
            write_reg(a[4:0], wd);
            read_reg(a[4:0], new_v);
            check_word($sformatf("write_mask_%0d", a), ref_write(a[4:0], old_v, wd), new_v);
        end

        // Known state, then eret out of ERL and EXL
        write_reg(cp0_pkg::REG_STATUS, 32'h0000_0002);
        write_reg(cp0_pkg::REG_COUNT, 32'd0);
        write_reg(cp0_pkg::REG_COMPARE, 32'h8000_0000);
        do_eret("eret_erl");
        read_reg(cp0_pkg::REG_STATUS, st);
        check_word("eret_erl_bits", 32'd1, {30'b0, st.erl, st.exl});
        do_eret("eret_exl");
        read_reg(cp0_pkg::REG_STATUS, st);
        check_word("eret_exl_bits", 32'd0, {30'b0, st.erl, st.exl});

        // Entry and nested entry
        for (int i = 0; i < 20; i++) begin
            read_reg(cp0_pkg::REG_BADVADDR, old_v);
            r = gen_req();
            apply_req("exception_entry", r, 1'b0, taken, code);
            exp_epc = r.in_delay_slot ? r.pc - 32'd4 : r.pc;
            exp_bd = r.in_delay_slot;
            read_reg(cp0_pkg::REG_EPC, new_v);
            check_word("entry_epc", exp_epc, new_v);
            read_reg(cp0_pkg::REG_CAUSE, ca);
            check_word("entry_bd", {31'b0, exp_bd}, {31'b0, ca.bd});
            if (code == cp0_pkg::CODE_ADEL || code == cp0_pkg::CODE_ADES) begin
                old_v = r.fetch_addr_err ? r.pc : r.data_addr;
            end
            read_reg(cp0_pkg::REG_BADVADDR, new_v);
            check_word("entry_badvaddr", old_v, new_v);

            r = gen_req();
            apply_req("nested_exception", r, 1'b0, taken, code);
            read_reg(cp0_pkg::REG_EPC, new_v);
            check_word("nested_epc", exp_epc, new_v);
            read_reg(cp0_pkg::REG_CAUSE, ca);
            check_word("nested_bd", {31'b0, exp_bd}, {31'b0, ca.bd});
            write_reg(cp0_pkg::REG_STATUS, 32'd0);
        end

        // Eret colliding with an exception
        apply_req("eret_collision", gen_req(), 1'b1, taken, code);
        write_reg(cp0_pkg::REG_STATUS, 32'd0);

        // ##################################################
        // Timer
        // ##################################################
        read_reg(cp0_pkg::REG_COUNT, c0);
        repeat (20) step();
        read_reg(cp0_pkg::REG_COUNT, new_v);
        check_word("count_rate", c0 + 32'd10, new_v);
        write_reg(cp0_pkg::REG_COMPARE, new_v + 32'd3);
        repeat (12) step();
        read_reg(cp0_pkg::REG_CAUSE, ca);
        check_word("timer_flag_set", 32'd1, {31'b0, ca.ip[7]});
        write_reg(cp0_pkg::REG_STATUS, 32'h0000_8001);
        r = '0;
        r.valid = 1'b1;
        apply_req("timer_interrupt", r, 1'b0, taken, code);
        check_word("timer_interrupt_taken", 32'd1, {31'b0, taken});
        read_reg(cp0_pkg::REG_COUNT, c0);
        write_reg(cp0_pkg::REG_COMPARE, c0 + 32'd1000);
        read_reg(cp0_pkg::REG_CAUSE, ca);
        check_word("timer_flag_clear", 32'd0, {31'b0, ca.ip[7]});

        // Software interrupt, then masked by IM and by IE
        write_reg(cp0_pkg::REG_CAUSE, 32'h0000_0100);
        write_reg(cp0_pkg::REG_STATUS, 32'h0000_0101);
        apply_req("soft_interrupt", r, 1'b0, taken, code);
        check_word("soft_interrupt_taken", 32'd1, {31'b0, taken});
        write_reg(cp0_pkg::REG_STATUS, 32'h0000_0001);
        apply_req("soft_masked_im", r, 1'b0, taken, code);
        check_word("soft_masked_im_taken", 32'd0, {31'b0, taken});
        write_reg(cp0_pkg::REG_STATUS, 32'h0000_0100);
        apply_req("soft_masked_ie", r, 1'b0, taken, code);
        check_word("soft_masked_ie_taken", 32'd0, {31'b0, taken});
        write_reg(cp0_pkg::REG_CAUSE, 32'd0);

        // Hardware line 2 lands on IP[4]
        hw_int = 5'b00100;
        write_reg(cp0_pkg::REG_STATUS, 32'h0000_1001);
        apply_req("hw_interrupt", r, 1'b0, taken, code);
        check_word("hw_interrupt_taken", 32'd1, {31'b0, taken});
        write_reg(cp0_pkg::REG_STATUS, 32'h0000_0001);
        apply_req("hw_masked_im", r, 1'b0, taken, code);
        check_word("hw_masked_im_taken", 32'd0, {31'b0, taken});
        hw_int = '0;

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+dv
rtl/cp0_pkg.sv
rtl/cp0.sv
rtl/exception_unit.sv
rtl/cp0_subsystem.sv
dv/cp0_subsystem_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f verilog.f --top-module cp0_subsystem_tb -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim

clean:
	rm -rf obj_dir
